//--- source/gb_mem_pkg.sv
`default_nettype none

package gb_mem_pkg;

  typedef logic [7:0] byte_t;

  // Same 16 bits, flat for decode or page:offset for DMA
  typedef union packed {
    logic [15:0] flat;
    struct packed {
      byte_t page;
      byte_t offset;
    } paged;
  } gb_addr_t;

  typedef struct packed {
    gb_addr_t addr;
    byte_t    wdata;
    logic     write;
  } cpu_req_t;

  // RAM uses only the low address bits
  typedef struct packed {
    logic [15:0] addr;
    byte_t       wdata;
    logic        en;
    logic        we;
  } ram_port_t;

  typedef enum logic [2:0] {
    REGION_VRAM,
    REGION_WRAM,
    REGION_OAM,
    REGION_HRAM,
    REGION_DMA_REG,
    REGION_OPEN
  } mem_region_t;

  // Memory map
  localparam logic [15:0] VRAM_START   = 16'h8000;
  localparam logic [15:0] VRAM_END     = 16'h9FFF;
  localparam logic [15:0] WRAM_START   = 16'hC000;
  // Echo RAM folds onto work RAM up to here
  localparam logic [15:0] ECHO_END     = 16'hFDFF;
  localparam logic [15:0] OAM_START    = 16'hFE00;
  localparam logic [15:0] OAM_END      = 16'hFE9F;
  localparam logic [15:0] DMA_REG_ADDR = 16'hFF46;
  localparam logic [15:0] HRAM_START   = 16'hFF80;
  localparam logic [15:0] HRAM_END     = 16'hFFFE;

  // Bytes per OAM DMA
  localparam int DMA_LENGTH = 160;

  localparam int VRAM_ADDR_BITS = 13;
  localparam int WRAM_ADDR_BITS = 13;
  localparam int OAM_ADDR_BITS  = 8;
  localparam int HRAM_ADDR_BITS = 7;

  localparam byte_t OPEN_BUS_DATA = 8'hFF;

endpackage

`default_nettype wire

//--- source/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
  parameter int ADDR_BITS = 8
) (
  input  logic                  clk,
  input  gb_mem_pkg::ram_port_t port,
  output gb_mem_pkg::byte_t     rdata
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  gb_mem_pkg::byte_t mem [DEPTH];

  logic [ADDR_BITS-1:0] index;

  assign index = port.addr[ADDR_BITS-1:0];

  // Read returns the old byte on a write
  always_ff @(posedge clk) begin
    if (port.en) begin
      if (port.we) begin
        mem[index] <= port.wdata;
      end
      rdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

//--- source/oam_dma.sv
`timescale 1ns/1ps
`default_nettype none

module oam_dma (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  gb_mem_pkg::byte_t    page,
  output logic                 busy,
  output logic                 src_rd,
  output gb_mem_pkg::gb_addr_t src_addr,
  input  gb_mem_pkg::byte_t    src_data,
  output logic                 oam_wr,
  output gb_mem_pkg::byte_t    oam_index,
  output gb_mem_pkg::byte_t    oam_wdata
);

  localparam gb_mem_pkg::byte_t LAST_OFFSET =
    gb_mem_pkg::byte_t'(gb_mem_pkg::DMA_LENGTH - 1);

  gb_mem_pkg::byte_t page_q;
  gb_mem_pkg::byte_t offset;
  logic              rd_active;

  // Stage 1 reads, stage 2 writes the byte read one cycle earlier
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_active <= 1'b0;
      offset    <= '0;
      oam_wr    <= 1'b0;
    end else begin
      if (start) begin
        rd_active <= 1'b1;
        offset    <= '0;
      end else if (rd_active) begin
        offset <= offset + 8'd1;
        if (offset == LAST_OFFSET) rd_active <= 1'b0;
      end
      oam_wr <= rd_active;
    end
  end

  always_ff @(posedge clk) begin
    if (start) page_q <= page;
    oam_index <= offset;
  end

  always_comb begin
    src_addr.paged.page   = page_q;
    src_addr.paged.offset = offset;
  end

  assign src_rd    = rd_active;
  assign busy      = rd_active | oam_wr;
  assign oam_wdata = src_data;

endmodule

`default_nettype wire

//--- source/mmu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,
  input  gb_mem_pkg::cpu_req_t  req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output gb_mem_pkg::byte_t     rsp_data,
  output gb_mem_pkg::ram_port_t vram_port,
  output gb_mem_pkg::ram_port_t wram_port,
  output gb_mem_pkg::ram_port_t oam_port,
  output gb_mem_pkg::ram_port_t hram_port,
  input  gb_mem_pkg::byte_t     vram_rdata,
  input  gb_mem_pkg::byte_t     wram_rdata,
  input  gb_mem_pkg::byte_t     oam_rdata,
  input  gb_mem_pkg::byte_t     hram_rdata,
  output logic                  dma_start,
  output gb_mem_pkg::byte_t     dma_page,
  input  logic                  dma_busy,
  input  logic                  dma_src_rd,
  input  logic                  dma_oam_wr,
  input  gb_mem_pkg::gb_addr_t  dma_src_addr,
  input  gb_mem_pkg::byte_t     dma_oam_index,
  input  gb_mem_pkg::byte_t     dma_oam_wdata,
  output gb_mem_pkg::byte_t     dma_src_data
);

  function automatic gb_mem_pkg::mem_region_t decode_region(input logic [15:0] a);
    gb_mem_pkg::mem_region_t r;
    if (a inside {[gb_mem_pkg::VRAM_START : gb_mem_pkg::VRAM_END]}) begin
      r = gb_mem_pkg::REGION_VRAM;
    end else if (a inside {[gb_mem_pkg::WRAM_START : gb_mem_pkg::ECHO_END]}) begin
      r = gb_mem_pkg::REGION_WRAM;
    end else if (a inside {[gb_mem_pkg::OAM_START : gb_mem_pkg::OAM_END]}) begin
      r = gb_mem_pkg::REGION_OAM;
    end else if (a inside {[gb_mem_pkg::HRAM_START : gb_mem_pkg::HRAM_END]}) begin
      r = gb_mem_pkg::REGION_HRAM;
    end else if (a == gb_mem_pkg::DMA_REG_ADDR) begin
      r = gb_mem_pkg::REGION_DMA_REG;
    end else begin
      r = gb_mem_pkg::REGION_OPEN;
    end
    return r;
  endfunction

  gb_mem_pkg::mem_region_t req_region;
  gb_mem_pkg::mem_region_t src_region;
  gb_mem_pkg::mem_region_t rsp_region;
  gb_mem_pkg::mem_region_t src_region_q;
  gb_mem_pkg::ram_port_t   cpu_port;
  gb_mem_pkg::ram_port_t   src_port;
  gb_mem_pkg::ram_port_t   oam_dma_port;
  gb_mem_pkg::byte_t       dma_reg;
  logic                    accept;

  assign req_region = decode_region(req.addr.flat);
  assign src_region = decode_region(dma_src_addr.flat);

  // Only high RAM stays reachable during a DMA
  assign req_ready = !dma_busy || (req_region == gb_mem_pkg::REGION_HRAM);
  assign accept    = req_valid && req_ready;

  assign dma_start = accept && req.write && (req_region == gb_mem_pkg::REGION_DMA_REG);
  assign dma_page  = req.wdata;

  always_comb begin
    cpu_port.addr  = req.addr.flat;
    cpu_port.wdata = req.wdata;
    cpu_port.en    = accept;
    cpu_port.we    = accept && req.write;

    src_port.addr  = dma_src_addr.flat;
    src_port.wdata = '0;
    src_port.en    = dma_src_rd;
    src_port.we    = 1'b0;

    oam_dma_port.addr  = {gb_mem_pkg::OAM_START[15:8], dma_oam_index};
    oam_dma_port.wdata = dma_oam_wdata;
    oam_dma_port.en    = dma_oam_wr;
    oam_dma_port.we    = dma_oam_wr;
  end

  always_comb begin
    vram_port = '0;
    wram_port = '0;
    oam_port  = '0;
    hram_port = '0;
    case (req_region)
      gb_mem_pkg::REGION_VRAM: vram_port = cpu_port;
      gb_mem_pkg::REGION_WRAM: wram_port = cpu_port;
      gb_mem_pkg::REGION_OAM:  oam_port  = cpu_port;
      gb_mem_pkg::REGION_HRAM: hram_port = cpu_port;
      default: ;
    endcase
    // Sequencer owns its source RAM and OAM while busy
    if (dma_busy) begin
      if (src_region == gb_mem_pkg::REGION_VRAM) vram_port = src_port;
      if (src_region == gb_mem_pkg::REGION_WRAM) wram_port = src_port;
      oam_port = oam_dma_port;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp_valid    <= 1'b0;
      rsp_region   <= gb_mem_pkg::REGION_OPEN;
      src_region_q <= gb_mem_pkg::REGION_OPEN;
      dma_reg      <= '0;
    end else begin
      rsp_valid <= accept && !req.write;
      if (accept && !req.write) rsp_region <= req_region;
      if (dma_src_rd) src_region_q <= src_region;
      if (dma_start) dma_reg <= dma_page;
    end
  end

  always_comb begin
    case (rsp_region)
      gb_mem_pkg::REGION_VRAM:    rsp_data = vram_rdata;
      gb_mem_pkg::REGION_WRAM:    rsp_data = wram_rdata;
      gb_mem_pkg::REGION_OAM:     rsp_data = oam_rdata;
      gb_mem_pkg::REGION_HRAM:    rsp_data = hram_rdata;
      gb_mem_pkg::REGION_DMA_REG: rsp_data = dma_reg;
      default:                    rsp_data = gb_mem_pkg::OPEN_BUS_DATA;
    endcase
  end

  // DMA sources other than VRAM and WRAM read as open bus
  always_comb begin
    case (src_region_q)
      gb_mem_pkg::REGION_VRAM: dma_src_data = vram_rdata;
      gb_mem_pkg::REGION_WRAM: dma_src_data = wram_rdata;
      default:                 dma_src_data = gb_mem_pkg::OPEN_BUS_DATA;
    endcase
  end

endmodule

`default_nettype wire

//--- source/gb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module gb_memory (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  gb_mem_pkg::cpu_req_t req,
  output logic                 req_ready,
  output logic                 rsp_valid,
  output gb_mem_pkg::byte_t    rsp_data
);

  gb_mem_pkg::ram_port_t vram_port;
  gb_mem_pkg::ram_port_t wram_port;
  gb_mem_pkg::ram_port_t oam_port;
  gb_mem_pkg::ram_port_t hram_port;
  gb_mem_pkg::byte_t     vram_rdata;
  gb_mem_pkg::byte_t     wram_rdata;
  gb_mem_pkg::byte_t     oam_rdata;
  gb_mem_pkg::byte_t     hram_rdata;

  // Control to DMA sequencer
  logic                 dma_start;
  gb_mem_pkg::byte_t    dma_page;
  logic                 dma_busy;
  logic                 dma_src_rd;
  gb_mem_pkg::gb_addr_t dma_src_addr;
  gb_mem_pkg::byte_t    dma_src_data;
  logic                 dma_oam_wr;
  gb_mem_pkg::byte_t    dma_oam_index;
  gb_mem_pkg::byte_t    dma_oam_wdata;

  mmu_ctrl i_ctrl (
    .clk, .reset, .req_valid, .req, .req_ready, .rsp_valid, .rsp_data,
    .vram_port, .wram_port, .oam_port, .hram_port,
    .vram_rdata, .wram_rdata, .oam_rdata, .hram_rdata,
    .dma_start, .dma_page, .dma_busy, .dma_src_rd, .dma_oam_wr,
    .dma_src_addr, .dma_oam_index, .dma_oam_wdata, .dma_src_data
  );

  oam_dma i_dma (
    .clk, .reset,
    .start     (dma_start),
    .page      (dma_page),
    .busy      (dma_busy),
    .src_rd    (dma_src_rd),
    .src_addr  (dma_src_addr),
    .src_data  (dma_src_data),
    .oam_wr    (dma_oam_wr),
    .oam_index (dma_oam_index),
    .oam_wdata (dma_oam_wdata)
  );

  sync_ram #(.ADDR_BITS(gb_mem_pkg::VRAM_ADDR_BITS)) i_vram (
    .clk, .port(vram_port), .rdata(vram_rdata)
  );
  sync_ram #(.ADDR_BITS(gb_mem_pkg::WRAM_ADDR_BITS)) i_wram (
    .clk, .port(wram_port), .rdata(wram_rdata)
  );
  sync_ram #(.ADDR_BITS(gb_mem_pkg::OAM_ADDR_BITS)) i_oam (
    .clk, .port(oam_port), .rdata(oam_rdata)
  );
  sync_ram #(.ADDR_BITS(gb_mem_pkg::HRAM_ADDR_BITS)) i_hram (
    .clk, .port(hram_port), .rdata(hram_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/gb_memory_checker.sv
`timescale 1ns/1ps
`default_nettype none

module gb_memory_checker (
  input logic                 clk,
  input logic                 reset,
  input logic                 req_valid,
  input gb_mem_pkg::cpu_req_t req,
  input logic                 req_ready,
  input logic                 rsp_valid,
  input logic                 dma_busy
);

  logic read_accept;
  logic in_hram;

  assign read_accept = req_valid && req_ready && !req.write;
  assign in_hram     = (req.addr.flat >= gb_mem_pkg::HRAM_START) &&
                       (req.addr.flat <= gb_mem_pkg::HRAM_END);

  // Response only in the cycle after an accepted read
  rsp_after_read: assert property (@(posedge clk) disable iff (reset)
    rsp_valid |-> $past(read_accept))
    else $error("rsp_valid without an accepted read one cycle earlier");

  req_held: assert property (@(posedge clk) disable iff (reset)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request dropped or changed while waiting for req_ready");

  stall_hram_only: assert property (@(posedge clk) disable iff (reset)
    dma_busy && req_valid && req_ready |-> in_hram)
    else $error("request outside high RAM accepted during DMA");

endmodule

`default_nettype wire

//--- testbench/gb_memory_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gb_memory_tb;

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 16;
  localparam int DRIVE_DELAY     = 1;
  localparam int HANDSHAKE_LIMIT = 400;
  localparam int DMA_BUSY_CYCLES = 161;
  // All tests take roughly 1200 cycles
  localparam int WATCHDOG_CYCLES = 2500;

  logic                 clk;
  logic                 reset;
  logic                 req_valid;
  gb_mem_pkg::cpu_req_t req;
  logic                 req_ready;
  logic                 rsp_valid;
  gb_mem_pkg::byte_t    rsp_data;

  int error_count  = 0;
  int check_count  = 0;
  int cycle_count  = 0;
  int accept_cycle = 0;

  gb_mem_pkg::byte_t src_bytes [160];

  gb_memory i_dut (
    .clk, .reset, .req_valid, .req, .req_ready, .rsp_valid, .rsp_data
  );

  bind gb_memory gb_memory_checker i_checker (
    .clk, .reset, .req_valid, .req, .req_ready, .rsp_valid, .dma_busy
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  task automatic check_data(input string name, input gb_mem_pkg::byte_t got,
                            input gb_mem_pkg::byte_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s = %02h, expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // ready_edge > 0 means req_ready must stay low until that clock edge
  task automatic issue_request(input logic [15:0] addr, input gb_mem_pkg::byte_t wdata,
                               input logic write, input int ready_edge);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    req_valid     = 1'b1;
    req.addr.flat = addr;
    req.wdata     = wdata;
    req.write     = write;
    while (!accepted && waited < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      if (ready_edge > 0) begin
        check_flag("req_ready", req_ready, cycle_count >= ready_edge);
      end
      accepted = req_ready;
      waited++;
      @(posedge clk);
      #DRIVE_DELAY;
    end
    req_valid    = 1'b0;
    accept_cycle = cycle_count;
    if (!accepted) begin
      error_count++;
      $display("Request to %04h was never accepted", addr);
    end
  endtask

  task automatic write_byte(input logic [15:0] addr, input gb_mem_pkg::byte_t data);
    issue_request(addr, data, 1'b1, 0);
  endtask

  task automatic read_byte(input logic [15:0] addr, input int ready_edge,
                           output gb_mem_pkg::byte_t data);
    issue_request(addr, 8'h00, 1'b0, ready_edge);
    @(negedge clk);
    if (rsp_valid !== 1'b1) begin
      error_count++;
      $display("No response in the cycle after the read of %04h", addr);
    end
    data = rsp_data;
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic read_check(input logic [15:0] addr, input gb_mem_pkg::byte_t exp);
    gb_mem_pkg::byte_t got;
    read_byte(addr, 0, got);
    check_data($sformatf("rsp_data[%04h]", addr), got, exp);
  endtask

  task automatic test_ram_readback();
    logic [15:0]       addrs [12] = '{16'h8000, 16'h9000, 16'h9FFF, 16'hC000, 16'hD000,
                                      16'hDFFF, 16'hFE00, 16'hFE50, 16'hFE9F, 16'hFF80,
                                      16'hFFBF, 16'hFFFE};
    gb_mem_pkg::byte_t expected [12];
    foreach (addrs[i]) begin
      expected[i] = gb_mem_pkg::byte_t'($urandom);
      write_byte(addrs[i], expected[i]);
    end
    foreach (addrs[i]) read_check(addrs[i], expected[i]);
  endtask

  task automatic test_echo_mirror();
    gb_mem_pkg::byte_t a;
    gb_mem_pkg::byte_t b;
    gb_mem_pkg::byte_t c;
    a = gb_mem_pkg::byte_t'($urandom);
    b = gb_mem_pkg::byte_t'($urandom);
    c = gb_mem_pkg::byte_t'($urandom);
    write_byte(16'hE123, a);
    read_check(16'hC123, a);
    write_byte(16'hC456, b);
    read_check(16'hE456, b);
    // Top of echo lands on DDFF
    write_byte(16'hFDFF, c);
    read_check(16'hDDFF, c);
  endtask

  task automatic test_open_bus();
    logic [15:0] addrs [5] = '{16'h0000, 16'hA000, 16'hFEA0, 16'hFF00, 16'hFF40};
    foreach (addrs[i]) read_check(addrs[i], 8'hFF);
    write_byte(16'hFF00, 8'h5A);
    read_check(16'hFF00, 8'hFF);
  endtask

  task automatic test_dma_copy();
    gb_mem_pkg::byte_t hram_val;
    gb_mem_pkg::byte_t got;
    int                dma_edge;
    // DMA register holds its reset value until the first DMA
    read_check(16'hFF46, 8'h00);
    for (int i = 0; i < 160; i++) begin
      src_bytes[i] = gb_mem_pkg::byte_t'($urandom);
      write_byte(16'(16'hC100 + i), src_bytes[i]);
    end
    write_byte(16'hFF46, 8'hC1);
    dma_edge = accept_cycle;
    // High RAM stays usable during the copy
    hram_val = gb_mem_pkg::byte_t'($urandom);
    write_byte(16'hFF90, hram_val);
    read_check(16'hFF90, hram_val);
    read_byte(16'h8000, dma_edge + DMA_BUSY_CYCLES, got);
    for (int i = 0; i < 160; i++) read_check(16'(16'hFE00 + i), src_bytes[i]);
    read_check(16'hFF46, 8'hC1);
  endtask

  task automatic test_dma_open_page();
    gb_mem_pkg::byte_t got;
    write_byte(16'hFF46, 8'h40);
    read_byte(16'hFE00, accept_cycle + DMA_BUSY_CYCLES, got);
    check_data("rsp_data[fe00]", got, 8'hFF);
    for (int i = 1; i < 160; i++) read_check(16'(16'hFE00 + i), 8'hFF);
  endtask

  initial begin
    void'($urandom(32'h3e22_527f));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(negedge clk);
    check_flag("req_ready", req_ready, 1'b1);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    @(posedge clk);
    #DRIVE_DELAY;
    test_ram_readback();
    test_echo_mirror();
    test_open_bus();
    test_dma_copy();
    test_dma_open_page();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
source/gb_mem_pkg.sv
source/sync_ram.sv
source/oam_dma.sv
source/mmu_ctrl.sv
source/gb_memory.sv
testbench/gb_memory_checker.sv
testbench/gb_memory_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = gb_memory_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
